// ==== wiscPipe.f ====
hw/wiscPkg.sv
hw/branchUnit.sv
hw/instrDecode.sv
hw/regFile.sv
hw/aluExecute.sv
hw/resultStage.sv
hw/wiscPipe.sv
testbench/wiscPipeTb.sv

// ==== Bender.yml ====
package:
  name: wiscPipe

sources:
  # package first, then the stages, then the top level
  - files:
      - hw/wiscPkg.sv
      - hw/branchUnit.sv
      - hw/instrDecode.sv
      - hw/regFile.sv
      - hw/aluExecute.sv
      - hw/resultStage.sv
      - hw/wiscPipe.sv
  - target: simulation
    files:
      - testbench/wiscPipeTb.sv

// ==== testbench/wiscPipeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

// directed tests for the three-stage wisc core
module wiscPipeTb import wiscPkg::*; ();

    localparam int memWords = 256;
    localparam int drainCycles = 4;
    localparam int modelSteps = 200;
    localparam longint cycleNs = 20;
    localparam logic [dataWidth-1:0] haltWord = {opHalt, 11'd0};
    localparam logic [dataWidth-1:0] nopWord = {opNop, 11'd0};

    logic                    clk;
    logic                    arstN;
    logic [dataWidth-1:0]    imemAddr;
    logic [dataWidth-1:0]    imemData;
    logic                    wbValid;
    logic [regAddrWidth-1:0] wbReg;
    logic [dataWidth-1:0]    wbData;
    logic                    halted;

    logic [dataWidth-1:0] progMem [memWords];
    int                   progLen;
    resultT               expQ [$];
    resultT               gotQ [$];
    logic [dataWidth-1:0] expPc;
    logic [dataWidth-1:0] haltPc;
    logic [31:0]          lfsrState = 32'h0acdeb25;
    int                   errorCount = 0;
    int                   checkCount = 0;
    // watchdog limit in ns grows with each loaded instruction
    longint               timeBudget = 4000;

    wiscPipe dut_i (
        .clk      (clk),
        .arstN    (arstN),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .halted   (halted)
    );

    // word-addressed program memory answers the pc combinationally
    assign imemData = progMem[imemAddr[8:1]];

    initial begin
        clk = 1'b0;
        forever #(cycleNs / 2) clk = ~clk;
    end

    initial begin
        while ($time <= timeBudget) begin
            #100;
        end
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("Test failed");
        $finish;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
            v = {v[14:0], lfsrState[0]};
        end
        return v;
    endfunction

    // instruction encoders
    function automatic logic [15:0] rInstr(aluOpT fn, int rd, int rs, int rt);
        return {opAdd, rs[2:0], rt[2:0], rd[2:0], fn};
    endfunction

    // lbi, beqz, bnez and jr share rs plus imm8
    function automatic logic [15:0] iInstr(opcodeT op, int rs, int imm);
        return {op, rs[2:0], imm[7:0]};
    endfunction

    function automatic logic [15:0] addiInstr(int rd, int rs, int imm);
        return {opAddi, rs[2:0], rd[2:0], imm[4:0]};
    endfunction

    function automatic logic [15:0] jInstr(int imm);
        return {opJ, imm[10:0]};
    endfunction

    task automatic checkResult(input resultT got, input resultT exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch at %0t: %s got r%0d=%h, expected r%0d=%h",
                     $time, what, got.rd, got.data, exp.rd, exp.data);
        end
    endtask

    task automatic checkPc(input logic [dataWidth-1:0] got, input logic [dataWidth-1:0] exp,
                           input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // unused words are HALT tagged with their own index
    task automatic clearProgram();
        int i;
        for (i = 0; i < memWords; i++) begin
            progMem[i] = {opHalt, 3'b000, 8'(i)};
        end
        progLen = 0;
    endtask

    task automatic placeAt(input int addr, input logic [15:0] word);
        progMem[addr / 2] = word;
        progLen++;
        timeBudget += 2 * cycleNs;
    endtask

    task automatic emit(input logic [15:0] word);
        placeAt(2 * progLen, word);
    endtask

    // four cycles low once releaseReset has run
    task automatic holdReset();
        @(posedge clk);
        arstN <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic releaseReset();
        @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkBit(wbValid, 1'b0, "wbValid after reset");
        checkBit(halted, 1'b0, "halted after reset");
        checkPc(imemAddr, 16'h0000, "pc after reset");
    endtask

    // architectural model steps one instruction at a time up to HALT
    task automatic runModel();
        logic [15:0] regs [8];
        logic [15:0] pc;
        logic [15:0] w;
        logic [15:0] rsVal;
        logic [15:0] rtVal;
        logic [15:0] imm8;
        logic [15:0] next;
        resultT      wr;
        int          steps;
        expQ.delete();
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        pc = '0;
        steps = 0;
        while (progMem[pc[8:1]][15:11] != opHalt && steps < modelSteps) begin
            w = progMem[pc[8:1]];
            rsVal = regs[w[10:8]];
            rtVal = regs[w[7:5]];
            imm8 = {{8{w[7]}}, w[7:0]};
            next = pc + 16'd2;
            wr = '0;
            case (w[15:11])
                opAdd: begin
                    case (w[1:0])
                        2'd0:    wr.data = rsVal + rtVal;
                        2'd1:    wr.data = rsVal - rtVal;
                        2'd2:    wr.data = rsVal & rtVal;
                        default: wr.data = rsVal ^ rtVal;
                    endcase
                    wr.valid = 1'b1;
                    wr.rd = w[4:2];
                end
                opAddi:  wr = '{valid: 1'b1, rd: w[7:5], data: rsVal + {{11{w[4]}}, w[4:0]}};
                // lbi writes its rs field
                opLbi:   wr = '{valid: 1'b1, rd: w[10:8], data: imm8};
                opBeqz:  next = (rsVal == 16'd0) ? next + imm8 : next;
                opBnez:  next = (rsVal != 16'd0) ? next + imm8 : next;
                opJ:     next = next + {{5{w[10]}}, w[10:0]};
                opJr:    next = rsVal + imm8;
                default: ;
            endcase
            if (wr.valid) begin
                regs[wr.rd] = wr.data;
                expQ.push_back(wr);
            end
            pc = next;
            steps++;
        end
        if (steps == modelSteps) begin
            errorCount++;
            $display("model ran %0d steps without reaching HALT", modelSteps);
        end
        expPc = pc;
    endtask

    task automatic sampleWb();
        if (wbValid) begin
            gotQ.push_back(resultT'{1'b1, wbReg, wbData});
        end
    endtask

    // model, release, trace until halted, drain, compare
    task automatic runProgram(input string name, input int startErrors);
        int cycles;
        int i;
        runModel();
        releaseReset();
        gotQ.delete();
        cycles = 0;
        while (!halted && cycles < 2 * progLen + 16) begin
            @(negedge clk);
            sampleWb();
            cycles++;
        end
        if (!halted) begin
            errorCount++;
            $display("%s: halted never rose within %0d cycles", name, cycles);
        end else begin
            haltPc = imemAddr;
            // pipeline is empty by now so any writeback here is extra
            repeat (drainCycles) begin
                @(negedge clk);
                sampleWb();
                checkBit(halted, 1'b1, "halted held");
                checkPc(imemAddr, haltPc, "pc held on HALT");
            end
            checkPc(haltPc, expPc, {name, " HALT address"});
        end
        if (gotQ.size() != expQ.size()) begin
            errorCount++;
            $display("Mismatch at %0t: %s made %0d writebacks, expected %0d",
                     $time, name, gotQ.size(), expQ.size());
        end
        for (i = 0; i < gotQ.size() && i < expQ.size(); i++) begin
            checkResult(gotQ[i], expQ[i], $sformatf("%s writeback %0d", name, i));
        end
        $display("%s: %0d errors", name, errorCount - startErrors);
    endtask

    task automatic aluOps();
        int i;
        holdReset();
        clearProgram();
        // random bytes into r1..r4
        for (i = 1; i <= 4; i++) begin
            emit(iInstr(opLbi, i, randBits(8)));
        end
        for (i = 0; i < 8; i++) begin
            emit(rInstr(aluOpT'(i % 4), randBits(3), randBits(3), randBits(3)));
        end
        emit(haltWord);
        runProgram("aluOps", errorCount);
    endtask

    task automatic forwardPaths();
        holdReset();
        clearProgram();
        emit(iInstr(opLbi, 1, 5));
        // rs from execute
        emit(addiInstr(2, 1, 3));
        // r1 from writeback, r2 from execute
        emit(rInstr(aluAdd, 3, 1, 2));
        emit(nopWord);
        emit(rInstr(aluSub, 4, 1, 3));
        emit(addiInstr(4, 4, -1));
        // r4 in both stages and execute must win
        emit(rInstr(aluXor, 5, 4, 3));
        emit(rInstr(aluAdd, 1, 1, 1));
        emit(rInstr(aluAnd, 6, 1, 5));
        emit(haltWord);
        runProgram("forwardPaths", errorCount);
    endtask

    task automatic branchSkips();
        holdReset();
        clearProgram();
        emit(iInstr(opLbi, 1, 0));
        // taken branch skips one
        emit(iInstr(opBeqz, 1, 2));
        emit(iInstr(opLbi, 2, 7));
        emit(iInstr(opLbi, 3, 9));
        emit(iInstr(opBeqz, 3, 2));
        emit(iInstr(opLbi, 4, 1));
        // taken branch skips two
        emit(iInstr(opBnez, 4, 4));
        emit(iInstr(opLbi, 5, 2));
        emit(iInstr(opLbi, 6, 3));
        emit(iInstr(opLbi, 7, 0));
        emit(nopWord);
        // not taken on r7 from writeback
        emit(iInstr(opBnez, 7, 2));
        emit(addiInstr(2, 7, 5));
        emit(haltWord);
        runProgram("branchSkips", errorCount);
    endtask

    task automatic jumpTargets();
        holdReset();
        clearProgram();
        placeAt(0, iInstr(opLbi, 1, 20));
        placeAt(2, iInstr(opJr, 1, 0));
        placeAt(4, iInstr(opLbi, 2, 8'h11));
        placeAt(20, iInstr(opLbi, 3, 8'h33));
        placeAt(22, jInstr(10));
        placeAt(24, iInstr(opLbi, 4, 8'h44));
        placeAt(34, iInstr(opLbi, 5, -2));
        placeAt(36, iInstr(opLbi, 6, 60));
        placeAt(38, nopWord);
        // negative offset on r6 from writeback
        placeAt(40, iInstr(opJr, 6, -4));
        placeAt(42, iInstr(opLbi, 2, 8'h22));
        placeAt(56, rInstr(aluAdd, 7, 3, 5));
        placeAt(58, jInstr(-16));
        placeAt(44, iInstr(opLbi, 2, 8'h55));
        placeAt(46, haltWord);
        runProgram("jumpTargets", errorCount);
    endtask

    task automatic haltHold();
        holdReset();
        clearProgram();
        emit(iInstr(opLbi, 1, 3));
        emit(addiInstr(1, 1, 1));
        emit(haltWord);
        // never fetched
        emit(iInstr(opLbi, 2, 9));
        emit(rInstr(aluAdd, 3, 1, 1));
        runProgram("haltHold", errorCount);
    endtask

    task automatic resetClear();
        int i;
        int firstErrors;
        firstErrors = errorCount;
        holdReset();
        clearProgram();
        for (i = 0; i < 8; i++) begin
            emit(iInstr(opLbi, i, 8'h80 + i));
        end
        emit(haltWord);
        releaseReset();
        // cut the run short while writebacks are in flight
        repeat (5) @(negedge clk);
        holdReset();
        @(negedge clk);
        checkBit(wbValid, 1'b0, "wbValid in reset");
        checkPc(imemAddr, 16'h0000, "pc in reset");
        clearProgram();
        // sources all read as zero
        emit(rInstr(aluAdd, 1, 2, 3));
        emit(rInstr(aluXor, 4, 5, 6));
        emit(rInstr(aluSub, 7, 0, 0));
        emit(rInstr(aluAnd, 0, 7, 4));
        emit(haltWord);
        runProgram("resetClear", firstErrors);
    endtask

    initial begin
        arstN = 1'b0;
        clearProgram();
        aluOps();
        forwardPaths();
        branchSkips();
        jumpTargets();
        haltHold();
        resetClear();
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/wiscPipe.sv ====
`timescale 1ns/1ps
`default_nettype none

// three-stage wisc core
// stage one fetches, decodes and resolves branches in one cycle
module wiscPipe import wiscPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    output logic [dataWidth-1:0]    imemAddr,
    input  logic [dataWidth-1:0]    imemData,
    output logic                    wbValid,
    output logic [regAddrWidth-1:0] wbReg,
    output logic [dataWidth-1:0]    wbData,
    output logic                    halted
);

    logic [dataWidth-1:0]    pc;
    logic [dataWidth-1:0]    nextPc;
    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [dataWidth-1:0]    rsValue;
    logic [dataWidth-1:0]    rtValue;
    logic [dataWidth-1:0]    rsFwd;
    logic [dataWidth-1:0]    imm;
    fwdSelT                  rsFwdSel;
    opcodeT                  opcode;
    decodedT                 decoded;
    resultT                  exResult;
    resultT                  wbResult;

    // instruction memory is read asynchronously off the pc
    assign imemAddr = pc;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc     <= resetPc;
            halted <= 1'b0;
        end else begin
            // halt already makes nextPc equal pc
            pc     <= nextPc;
            halted <= halted || (opcode == opHalt);
        end
    end

    // rt select is consumed inside decode
    instrDecode instrDecode_i (
        .clk      (clk),
        .arstN    (arstN),
        .instr    (imemData),
        .rsFwd    (rsFwd),
        .rtValue  (rtValue),
        .exData   (exResult.data),
        .wbData   (wbResult.data),
        .exResult (exResult),
        .wbResult (wbResult),
        .halted   (halted),
        .rsAddr   (rsAddr),
        .rtAddr   (rtAddr),
        .rsFwdSel (rsFwdSel),
        .rtFwdSel (),
        .opcode   (opcode),
        .imm      (imm),
        .decoded  (decoded)
    );

    // rs forwarding and next pc
    branchUnit branchUnit_i (
        .fwdSel  (rsFwdSel),
        .rsValue (rsValue),
        .exData  (exResult.data),
        .wbData  (wbResult.data),
        .pc      (pc),
        .imm     (imm),
        .opcode  (opcode),
        .rsFwd   (rsFwd),
        .nextPc  (nextPc)
    );

    regFile regFile_i (
        .clk     (clk),
        .arstN   (arstN),
        .rsAddr  (rsAddr),
        .rtAddr  (rtAddr),
        .wrEn    (wbResult.valid),
        .wrAddr  (wbResult.rd),
        .wrData  (wbResult.data),
        .rsValue (rsValue),
        .rtValue (rtValue)
    );

    aluExecute aluExecute_i (
        .decoded  (decoded),
        .exResult (exResult)
    );

    resultStage resultStage_i (
        .clk      (clk),
        .arstN    (arstN),
        .exResult (exResult),
        .wbResult (wbResult)
    );

    // writeback trace
    assign wbValid = wbResult.valid;
    assign wbReg   = wbResult.rd;
    assign wbData  = wbResult.data;

endmodule

`default_nettype wire

// ==== hw/resultStage.sv ====
`timescale 1ns/1ps
`default_nettype none

// ex/wb register
// single source for regfile write, wb forwarding and trace
module resultStage import wiscPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  resultT exResult,
    output resultT wbResult
);

    logic                    validQ;
    logic [regAddrWidth-1:0] rdQ;
    logic [dataWidth-1:0]    dataQ;

    // wb stage valid bit
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= exResult.valid;
        end
    end

    always_ff @(posedge clk) begin
        rdQ   <= exResult.rd;
        dataQ <= exResult.data;
    end

    assign wbResult = '{valid: validQ, rd: rdQ, data: dataQ};

endmodule

`default_nettype wire

// ==== hw/aluExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

// execute stage, purely combinational on the id/ex register
module aluExecute import wiscPkg::*; (
    input  decodedT decoded,
    output resultT  exResult
);

    logic [dataWidth-1:0] aluOut;

    always_comb begin
        case (decoded.aluOp)
            aluAdd:  aluOut = decoded.opA + decoded.opB;
            aluSub:  aluOut = decoded.opA - decoded.opB;
            aluAnd:  aluOut = decoded.opA & decoded.opB;
            aluXor:  aluOut = decoded.opA ^ decoded.opB;
            default: aluOut = '0;
        endcase
    end

    // write enable folds into valid from here on
    always_comb begin
        exResult.valid = decoded.valid && decoded.writeEn;
        exResult.rd    = decoded.rd;
        exResult.data  = aluOut;
    end

endmodule

`default_nettype wire

// ==== hw/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

// 8 x 16 register file
// two async read ports, one write port, r0 is an ordinary register
module regFile import wiscPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [regAddrWidth-1:0] rsAddr,
    input  logic [regAddrWidth-1:0] rtAddr,
    input  logic                    wrEn,
    input  logic [regAddrWidth-1:0] wrAddr,
    input  logic [dataWidth-1:0]    wrData,
    output logic [dataWidth-1:0]    rsValue,
    output logic [dataWidth-1:0]    rtValue
);

    logic [dataWidth-1:0] regs [numRegs];

    // all registers read as zero after reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // no write-through here
    // a same-cycle write is picked up by the wb forward path
    assign rsValue = regs[rsAddr];
    assign rtValue = regs[rtAddr];

endmodule

`default_nettype wire

// ==== hw/instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

// field split, control decode, forwarding selects and the id/ex register
module instrDecode import wiscPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [dataWidth-1:0]    instr,
    input  logic [dataWidth-1:0]    rsFwd,
    input  logic [dataWidth-1:0]    rtValue,
    input  logic [dataWidth-1:0]    exData,
    input  logic [dataWidth-1:0]    wbData,
    input  resultT                  exResult,
    input  resultT                  wbResult,
    input  logic                    halted,
    output logic [regAddrWidth-1:0] rsAddr,
    output logic [regAddrWidth-1:0] rtAddr,
    output fwdSelT                  rsFwdSel,
    output fwdSelT                  rtFwdSel,
    output opcodeT                  opcode,
    output logic [dataWidth-1:0]    imm,
    output decodedT                 decoded
);

    logic [dataWidth-1:0] rtFwd;
    decodedT              decodedNext;

    // ex holds the younger instruction and wins over wb
    function automatic fwdSelT fwdSelect(input logic [regAddrWidth-1:0] addr,
                                         input resultT ex,
                                         input resultT wb);
        fwdSelT sel;
        if (ex.valid && ex.rd == addr) begin
            sel = fwdEx;
        end else if (wb.valid && wb.rd == addr) begin
            sel = fwdWb;
        end else begin
            sel = fwdReg;
        end
        return sel;
    endfunction

    assign opcode = opcodeT'(instr[15:11]);
    assign rsAddr = instr[10:8];
    assign rtAddr = instr[7:5];

    // immediate width depends on format
    always_comb begin
        case (opcode)
            opAddi:                     imm = dataWidth'($signed(instr[4:0]));
            opLbi, opBeqz, opBnez, opJr: imm = dataWidth'($signed(instr[7:0]));
            opJ:                        imm = dataWidth'($signed(instr[10:0]));
            default:                    imm = '0;
        endcase
    end

    assign rsFwdSel = fwdSelect(rsAddr, exResult, wbResult);
    assign rtFwdSel = fwdSelect(rtAddr, exResult, wbResult);

    // rt mux lives here, rs mux sits in the branch unit
    always_comb begin
        case (rtFwdSel)
            fwdEx:   rtFwd = exData;
            fwdWb:   rtFwd = wbData;
            default: rtFwd = rtValue;
        endcase
    end

    always_comb begin
        decodedNext         = '0;
        decodedNext.aluOp   = aluAdd;
        case (opcode)
            opAdd: begin
                decodedNext.aluOp   = aluOpT'(instr[1:0]);
                decodedNext.opA     = rsFwd;
                decodedNext.opB     = rtFwd;
                decodedNext.writeEn = 1'b1;
                decodedNext.rd      = instr[4:2];
            end
            opAddi: begin
                decodedNext.opA     = rsFwd;
                decodedNext.opB     = imm;
                decodedNext.writeEn = 1'b1;
                decodedNext.rd      = instr[7:5];
            end
            // lbi is 0 + imm into rs
            opLbi: begin
                decodedNext.opB     = imm;
                decodedNext.writeEn = 1'b1;
                decodedNext.rd      = instr[10:8];
            end
            default: ;
        endcase
        // bubbles once halted
        decodedNext.valid = decodedNext.writeEn && !halted;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decoded <= '0;
        end else begin
            decoded <= decodedNext;
        end
    end

endmodule

`default_nettype wire

// ==== hw/branchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

// stage one next-pc logic
// branches resolve here on the forwarded rs, so nothing is flushed
module branchUnit import wiscPkg::*; (
    input  fwdSelT               fwdSel,
    input  logic [dataWidth-1:0] rsValue,
    input  logic [dataWidth-1:0] exData,
    input  logic [dataWidth-1:0] wbData,
    input  logic [dataWidth-1:0] pc,
    input  logic [dataWidth-1:0] imm,
    input  opcodeT               opcode,
    output logic [dataWidth-1:0] rsFwd,
    output logic [dataWidth-1:0] nextPc
);

    logic [dataWidth-1:0] pcInc;
    logic [dataWidth-1:0] pcImm;
    logic [dataWidth-1:0] rsImm;
    logic                 rsZero;
    logic                 takeBranch;

    // rs source, newest producer wins in decode
    always_comb begin
        case (fwdSel)
            fwdEx:   rsFwd = exData;
            fwdWb:   rsFwd = wbData;
            default: rsFwd = rsValue;
        endcase
    end

    // sequential and pc-relative targets
    assign pcInc = pc + pcStep;
    assign pcImm = pcInc + imm;

    // jr target is register based
    assign rsImm = rsFwd + imm;

    // zero test shared by beqz and bnez
    assign rsZero = (rsFwd == '0);

    always_comb begin
        case (opcode)
            opBeqz:  takeBranch = rsZero;
            opBnez:  takeBranch = !rsZero;
            default: takeBranch = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            // halt spins on its own address
            opHalt:        nextPc = pc;
            opJ:           nextPc = pcImm;
            opJr:          nextPc = rsImm;
            opBeqz, opBnez: nextPc = takeBranch ? pcImm : pcInc;
            default:       nextPc = pcInc;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/wiscPkg.sv ====
`default_nettype none

// shared types and constants for the wiscPipe core
package wiscPkg;

    // datapath and instruction width
    localparam int dataWidth = 16;

    // register index width
    localparam int regAddrWidth = 3;

    // eight architectural registers
    localparam int numRegs = 1 << regAddrWidth;

    // opcode field is bits 15:11
    localparam int opcodeWidth = 5;

    // function field of r-type, bits 1:0
    localparam int aluOpWidth = 2;

    // instructions are two bytes apart
    localparam logic [dataWidth-1:0] pcStep = 16'd2;

    // pc after reset
    localparam logic [dataWidth-1:0] resetPc = 16'd0;

    // major opcodes, encodings follow the wisc table
    typedef enum logic [opcodeWidth-1:0] {
        opHalt = 5'b00000,
        opNop  = 5'b00001,
        opJ    = 5'b00100,
        opJr   = 5'b00101,
        opAddi = 5'b01000,
        opBeqz = 5'b01100,
        opBnez = 5'b01101,
        opLbi  = 5'b11000,
        // r-type group, function in bits 1:0
        opAdd  = 5'b11011
    } opcodeT;

    // alu function
    typedef enum logic [aluOpWidth-1:0] {
        aluAdd = 2'b00,
        aluSub = 2'b01,
        aluAnd = 2'b10,
        aluXor = 2'b11
    } aluOpT;

    // operand source in decode
    typedef enum logic [1:0] {
        fwdReg = 2'b00,
        fwdWb  = 2'b01,
        fwdEx  = 2'b10
    } fwdSelT;

    // decode to execute bundle
    typedef struct packed {
        logic                    valid;
        aluOpT                   aluOp;
        logic [dataWidth-1:0]    opA;
        logic [dataWidth-1:0]    opB;
        logic                    writeEn;
        logic [regAddrWidth-1:0] rd;
    } decodedT;

    // execute and writeback bundle
    // valid already means "writes rd"
    typedef struct packed {
        logic                    valid;
        logic [regAddrWidth-1:0] rd;
        logic [dataWidth-1:0]    data;
    } resultT;

endpackage

`default_nettype wire
